/* hw/pipeTypes.sv */
`default_nettype none

// Instruction-side types shared by the tag pipes and forwarding.
package pipeTypes;

    typedef logic [4:0] regIdx;

    // Control tag carried by one issue slot.
    typedef struct packed {
        logic  regWrite;
        regIdx writeReg;
        logic  memRead;   // Load, data ready after M.
        logic  isMfc;     // mfc0, data ready after E.
        logic  readRs;
        logic  readRt;
        logic  delaySlot;
    } ctrlSign;

    typedef struct packed {
        ctrlSign master;
        ctrlSign slave;
    } slotPair;

    // Source of a decode operand. E codes use the upper two bits, elsewhere bit 2 marks the slave.
    typedef enum logic [3:0] {
        NONE      = 4'b0000,
        E_SLAVE   = 4'b1000,
        E_MASTER  = 4'b0100,
        M_SLAVE   = 4'b0111,
        M_MASTER  = 4'b0011,
        M2_SLAVE  = 4'b0110,
        M2_MASTER = 4'b0010,
        W_SLAVE   = 4'b0101,
        W_MASTER  = 4'b0001
    } fwdCode;

endpackage

`default_nettype wire

/* hw/hazardTypes.sv */
`default_nettype none

// Control-side types of the hazard unit.
package hazardTypes;

    // Result words per cycle, slave and master at E, M, M2 and W.
    localparam int RESULT_WORDS = 8;

    typedef struct packed {
        logic stallF;
        logic stallF2;
        logic stallMasterD;
        logic stallSlaveD;
        logic stallMasterE;
        logic stallSlaveE;
        logic stallMasterM;
        logic stallSlaveM;
        logic stallMasterM2;
        logic stallSlaveM2;
        logic stallMasterW;
        logic stallSlaveW;
        logic stallDBlank;   // Operand not ready yet.
    } stallVec;

    typedef struct packed {
        logic flushF;
        logic flushF2;
        logic flushMasterD;
        logic flushSlaveD;
        logic flushMasterE;
        logic flushSlaveE;
        logic flushMasterM;
        logic flushSlaveM;
        logic flushMasterM2;
        logic flushSlaveM2;
        logic flushW;
    } flushVec;

    typedef struct packed {
        logic       iCacheStall;
        logic       dCacheStall;
        logic       aluStallE;
        logic       masterOnlyOneD;
        logic       slaveOnlyOneD;
        logic       predFailedMasterE;
        logic       predFailedSlaveE;
        logic       excMasterM;
        logic       excSlaveM;
        logic [1:0] pcChange;   // Bit 0 master D, bit 1 slave D.
    } hazEvents;

endpackage

`default_nettype wire

/* hw/fwdSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module fwdSelect import pipeTypes::*; (
    input  wire slotPair  decD,
    input  wire regIdx    rs1D,
    input  wire regIdx    rt1D,
    input  wire regIdx    rs2D,
    input  wire regIdx    rt2D,
    input  wire slotPair  tagE,
    input  wire slotPair  tagM,
    input  wire slotPair  tagM2,
    input  wire slotPair  tagW,
    output fwdCode [3:0]  fwd   // rs1, rt1, rs2, rt2 from bit 0 up.
);

    // Tag writes the operand register. r0 is hardwired to zero.
    function automatic logic hit(input ctrlSign t, input regIdx idx);
        return t.regWrite && (t.writeReg == idx) && (idx != '0);
    endfunction

    // Youngest first, slave before master within a stage.
    function automatic fwdCode search(input regIdx idx, input logic reads);
        fwdCode code;
        if (!reads) begin
            code = NONE;   // Operand unused by this slot.
        end else if (hit(tagE.slave, idx)) begin
            code = E_SLAVE;
        end else if (hit(tagE.master, idx)) begin
            code = E_MASTER;
        end else if (hit(tagM.slave, idx)) begin
            code = M_SLAVE;
        end else if (hit(tagM.master, idx)) begin
            code = M_MASTER;
        end else if (hit(tagM2.slave, idx)) begin
            code = M2_SLAVE;
        end else if (hit(tagM2.master, idx)) begin
            code = M2_MASTER;
        end else if (hit(tagW.slave, idx)) begin
            code = W_SLAVE;
        end else if (hit(tagW.master, idx)) begin
            code = W_MASTER;
        end else begin
            code = NONE;
        end
        return code;
    endfunction

    always_comb begin
        fwd[0] = search(rs1D, decD.master.readRs);
        fwd[1] = search(rt1D, decD.master.readRt);
        fwd[2] = search(rs2D, decD.slave.readRs);
        fwd[3] = search(rt2D, decD.slave.readRt);
    end

endmodule

`default_nettype wire

/* hw/stagePipe.sv */
`timescale 1ns/10ps
`default_nettype none

// Control tags of one slot from E to W.
module stagePipe import pipeTypes::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire ctrlSign tagD,
    input  wire          stallE,
    input  wire          stallM,
    input  wire          stallM2,
    input  wire          stallW,
    input  wire          flushE,
    input  wire          flushM,
    input  wire          flushM2,
    input  wire          flushW,
    output ctrlSign      tagE,
    output ctrlSign      tagM,
    output ctrlSign      tagM2,
    output ctrlSign      tagW
);

    // Flush wins over stall in every stage.
    always_ff @(posedge clk) begin
        if (rst) begin
            tagE  <= '0;
            tagM  <= '0;
            tagM2 <= '0;
            tagW  <= '0;
        end else begin
            if (flushE) begin
                tagE <= '0;
            end else if (!stallE) begin
                tagE <= tagD;
            end

            if (flushM) begin
                tagM <= '0;
            end else if (!stallM) begin
                tagM <= tagE;
            end

            if (flushM2) begin
                tagM2 <= '0;
            end else if (!stallM2) begin
                tagM2 <= tagM;
            end

            if (flushW) begin
                tagW <= '0;   // Bubble into writeback.
            end else if (!stallW) begin
                tagW <= tagM2;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/bypassMux.sv */
`timescale 1ns/10ps
`default_nettype none

module bypassMux import pipeTypes::*, hazardTypes::*; #(
    parameter int DATA_W = 32
) (
    input  wire fwdCode [3:0]                    fwd,
    input  wire [RESULT_WORDS*DATA_W-1:0]        results,
    input  wire [3:0][DATA_W-1:0]                rfVal,
    output logic [3:0][DATA_W-1:0]               opVal
);

    // Result bus layout, first member in the top word.
    typedef struct packed {
        logic [DATA_W-1:0] slaveE;
        logic [DATA_W-1:0] masterE;
        logic [DATA_W-1:0] slaveM;
        logic [DATA_W-1:0] masterM;
        logic [DATA_W-1:0] slaveM2;
        logic [DATA_W-1:0] masterM2;
        logic [DATA_W-1:0] slaveW;
        logic [DATA_W-1:0] masterW;
    } stageResults;

    stageResults res;

    assign res = results;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (fwd[i])
                E_SLAVE:   opVal[i] = res.slaveE;
                E_MASTER:  opVal[i] = res.masterE;
                M_SLAVE:   opVal[i] = res.slaveM;
                M_MASTER:  opVal[i] = res.masterM;
                M2_SLAVE:  opVal[i] = res.slaveM2;
                M2_MASTER: opVal[i] = res.masterM2;
                W_SLAVE:   opVal[i] = res.slaveW;
                W_MASTER:  opVal[i] = res.masterW;
                default:   opVal[i] = rfVal[i];   // No producer in flight.
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/hazard.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard import pipeTypes::*, hazardTypes::*; (
    input  wire hazEvents     events,
    input  wire slotPair      decD,
    input  wire regIdx        rs2D,
    input  wire regIdx        rt2D,
    input  wire fwdCode [3:0] fwd,
    input  wire slotPair      tagE,
    input  wire slotPair      tagM,
    output stallVec           stall,
    output flushVec           flush,
    output logic              icacheCtl,
    output logic              flushEx
);

    logic cacheStall;
    logic longStall;
    logic predFailed;
    logic useE;
    logic useM;
    logic stallDBlank;
    logic onlyOne;
    logic pcChange1D;
    logic pcChange2D;

    function automatic logic namesE(input fwdCode c);
        return (c == E_SLAVE) || (c == E_MASTER);
    endfunction

    function automatic logic namesM(input fwdCode c);
        return (c == M_SLAVE) || (c == M_MASTER);
    endfunction

    always_comb begin
        cacheStall = events.iCacheStall | events.dCacheStall;
        longStall  = cacheStall | events.aluStallE;
        predFailed = events.predFailedMasterE | events.predFailedSlaveE;
        flushEx    = events.excMasterM | events.excSlaveM;
        pcChange1D = events.pcChange[0];
        pcChange2D = events.pcChange[1];

        useE = 1'b0;
        useM = 1'b0;
        for (int i = 0; i < 4; i++) begin
            useE = useE | namesE(fwd[i]);
            useM = useM | namesM(fwd[i]);
        end

        // Load or mfc0 still in E, or load still in M.
        stallDBlank = (useE & (tagE.master.memRead | tagE.master.isMfc
                              | tagE.slave.memRead | tagE.slave.isMfc))
                    | (useM & (tagM.master.memRead | tagM.slave.memRead));

        // Slave consumes what its own master writes.
        onlyOne = events.masterOnlyOneD | events.slaveOnlyOneD
                | (decD.master.regWrite
                   & ((decD.slave.readRs & (rs2D == decD.master.writeReg))
                      | (decD.slave.readRt & (rt2D == decD.master.writeReg))));

        icacheCtl = events.dCacheStall | events.aluStallE | stallDBlank | onlyOne;

        stall.stallF        = ~(flushEx | predFailed) & (longStall | stallDBlank | onlyOne);
        stall.stallF2       = longStall | stallDBlank | onlyOne;
        stall.stallMasterD  = longStall | stallDBlank;
        stall.stallSlaveD   = longStall | stallDBlank | onlyOne;
        stall.stallMasterE  = longStall;
        stall.stallSlaveE   = longStall;
        stall.stallMasterM  = longStall;
        stall.stallSlaveM   = longStall;
        stall.stallMasterM2 = ~events.excSlaveM & longStall;
        stall.stallSlaveM2  = longStall;
        stall.stallMasterW  = ~flushEx & longStall;
        stall.stallSlaveW   = ~flushEx & longStall;
        stall.stallDBlank   = stallDBlank;

        flush.flushF   = 1'b0;
        flush.flushF2  = flushEx | predFailed | pcChange1D | (pcChange2D & ~stall.stallF2);
        flush.flushMasterD = flushEx | events.predFailedMasterE
                           | ((pcChange1D | events.predFailedSlaveE | onlyOne)
                              & ~stall.stallMasterD);
        flush.flushSlaveD  = flushEx | predFailed
                           | ((pcChange1D | pcChange2D) & ~stall.stallSlaveD);
        flush.flushMasterE = flushEx
                           | ((events.predFailedMasterE | stallDBlank) & ~stall.stallMasterE);
        // Master mispredict also drops slave E when it is marked as delay slot.
        flush.flushSlaveE  = flushEx
                           | (((events.predFailedMasterE & tagE.slave.delaySlot)
                               | events.predFailedSlaveE | stallDBlank | onlyOne)
                              & ~stall.stallSlaveE);
        flush.flushMasterM  = flushEx;
        flush.flushSlaveM   = flushEx;
        flush.flushMasterM2 = events.excMasterM;   // Slave exception keeps the master.
        flush.flushSlaveM2  = flushEx;
        flush.flushW        = 1'b0;
    end

endmodule

`default_nettype wire

/* hw/hazardCore.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardCore import pipeTypes::*, hazardTypes::*; #(
    parameter int DATA_W = 32
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire slotPair                     decD,
    input  wire regIdx                       rs1D,
    input  wire regIdx                       rt1D,
    input  wire regIdx                       rs2D,
    input  wire regIdx                       rt2D,
    input  wire hazEvents                    events,
    input  wire [RESULT_WORDS*DATA_W-1:0]    results,
    input  wire [3:0][DATA_W-1:0]            rfVal,
    output stallVec                          stall,
    output flushVec                          flush,
    output logic                             icacheCtl,
    output logic                             flushEx,
    output fwdCode [3:0]                     fwd,
    output logic [3:0][DATA_W-1:0]           opVal
);

    wire slotPair tagE;
    wire slotPair tagM;
    wire slotPair tagM2;
    wire slotPair tagW;

    stagePipe masterPipe (
        .clk     (clk),
        .rst     (rst),
        .tagD    (decD.master),
        .stallE  (stall.stallMasterE),
        .stallM  (stall.stallMasterM),
        .stallM2 (stall.stallMasterM2),
        .stallW  (stall.stallMasterW),
        .flushE  (flush.flushMasterE),
        .flushM  (flush.flushMasterM),
        .flushM2 (flush.flushMasterM2),
        .flushW  (flush.flushW),
        .tagE    (tagE.master),
        .tagM    (tagM.master),
        .tagM2   (tagM2.master),
        .tagW    (tagW.master)
    );

    stagePipe slavePipe (
        .clk     (clk),
        .rst     (rst),
        .tagD    (decD.slave),
        .stallE  (stall.stallSlaveE),
        .stallM  (stall.stallSlaveM),
        .stallM2 (stall.stallSlaveM2),
        .stallW  (stall.stallSlaveW),
        .flushE  (flush.flushSlaveE),
        .flushM  (flush.flushSlaveM),
        .flushM2 (flush.flushSlaveM2),
        .flushW  (flush.flushW),
        .tagE    (tagE.slave),
        .tagM    (tagM.slave),
        .tagM2   (tagM2.slave),
        .tagW    (tagW.slave)
    );

    fwdSelect fwdSel (
        .decD  (decD),
        .rs1D  (rs1D),
        .rt1D  (rt1D),
        .rs2D  (rs2D),
        .rt2D  (rt2D),
        .tagE  (tagE),
        .tagM  (tagM),
        .tagM2 (tagM2),
        .tagW  (tagW),
        .fwd   (fwd)
    );

    bypassMux #(
        .DATA_W (DATA_W)
    ) bypass (
        .fwd     (fwd),
        .results (results),
        .rfVal   (rfVal),
        .opVal   (opVal)
    );

    hazard hazCtl (
        .events    (events),
        .decD      (decD),
        .rs2D      (rs2D),
        .rt2D      (rt2D),
        .fwd       (fwd),
        .tagE      (tagE),
        .tagM      (tagM),
        .stall     (stall),
        .flush     (flush),
        .icacheCtl (icacheCtl),
        .flushEx   (flushEx)
    );

endmodule

`default_nettype wire

/* tests/tb_hazardCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_hazardCore import pipeTypes::*, hazardTypes::*; ();

    localparam int DATA_W = 32;

    // One line of the case file.
    typedef struct packed {
        slotPair     decD;
        regIdx       rs1D;
        regIdx       rt1D;
        regIdx       rs2D;
        regIdx       rt2D;
        hazEvents    events;
        stallVec     stallExp;
        flushVec     flushExp;
        logic [15:0] fwdExp;   // rt2, rs2, rt1, rs1 from the top nibble down.
    } caseLine;

    logic                           clk;
    logic                           rst;
    slotPair                        decD;
    regIdx                          rs1D;
    regIdx                          rt1D;
    regIdx                          rs2D;
    regIdx                          rt2D;
    hazEvents                       events;
    logic [RESULT_WORDS*DATA_W-1:0] results;
    logic [3:0][DATA_W-1:0]         rfVal;
    stallVec                        stall;
    flushVec                        flush;
    logic                           icacheCtl;
    logic                           flushEx;
    fwdCode [3:0]                   fwd;
    logic [3:0][DATA_W-1:0]         opVal;

    caseLine cases[$];
    int      seed = 91220;
    int      cycles = 0;
    int      cycleLimit = 0;
    int      caseIdx = 0;

    hazardCore #(
        .DATA_W (DATA_W)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .decD      (decD),
        .rs1D      (rs1D),
        .rt1D      (rt1D),
        .rs2D      (rs2D),
        .rt2D      (rt2D),
        .events    (events),
        .results   (results),
        .rfVal     (rfVal),
        .stall     (stall),
        .flush     (flush),
        .icacheCtl (icacheCtl),
        .flushEx   (flushEx),
        .fwd       (fwd),
        .opVal     (opVal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            abortRun($sformatf("Timeout, the run went past %0d cycles.", cycleLimit));
        end
    end

    task automatic readCases();
        int                fd;
        int                n;
        logic [8*160-1:0]  text;
        logic [31:0]       f [10];
        caseLine           c;
        fd = $fopen("tests/hazard_cases.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open tests/hazard_cases.txt.");
        end else begin
            while ($fgets(text, fd) != 0) begin
                n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (n == 10) begin
                    c.decD.master = f[0][10:0];
                    c.decD.slave  = f[1][10:0];
                    c.rs1D        = f[2][4:0];
                    c.rt1D        = f[3][4:0];
                    c.rs2D        = f[4][4:0];
                    c.rt2D        = f[5][4:0];
                    c.events      = f[6][10:0];
                    c.stallExp    = f[7][12:0];
                    c.flushExp    = f[8][10:0];
                    c.fwdExp      = f[9][15:0];
                    cases.push_back(c);
                end else if (n > 0) begin
                    abortRun("A line of the case file has too few columns.");
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyCase(input caseLine c);
        decD   = c.decD;
        rs1D   = c.rs1D;
        rt1D   = c.rt1D;
        rs2D   = c.rs2D;
        rt2D   = c.rt2D;
        events = c.events;
        // Fresh random data every cycle.
        for (int i = 0; i < RESULT_WORDS; i++) begin
            results[i*DATA_W +: DATA_W] = $random(seed);
        end
        for (int i = 0; i < 4; i++) begin
            rfVal[i] = $random(seed);
        end
    endtask

    // Master W sits in the lowest word of the result bus, slave E in the top one.
    function automatic logic [DATA_W-1:0] expectedOperand(input fwdCode code, input int op);
        int                word;
        logic [DATA_W-1:0] val;
        case (code)
            W_MASTER:  word = 0;
            W_SLAVE:   word = 1;
            M2_MASTER: word = 2;
            M2_SLAVE:  word = 3;
            M_MASTER:  word = 4;
            M_SLAVE:   word = 5;
            E_MASTER:  word = 6;
            E_SLAVE:   word = 7;
            default:   word = -1;
        endcase
        if (word < 0) begin
            val = rfVal[op];   // Register file.
        end else begin
            val = results[word*DATA_W +: DATA_W];
        end
        return val;
    endfunction

    // I-cache hold for every fetch stall cause except its own miss.
    function automatic logic expectedIcacheCtl(input caseLine c);
        logic pairDep;
        pairDep = c.events.masterOnlyOneD | c.events.slaveOnlyOneD
                | (c.decD.master.regWrite
                   & ((c.decD.slave.readRs & (c.rs2D == c.decD.master.writeReg))
                      | (c.decD.slave.readRt & (c.rt2D == c.decD.master.writeReg))));
        return c.events.dCacheStall | c.events.aluStallE | c.stallExp.stallDBlank | pairDep;
    endfunction

    task automatic checkStall(input stallVec got, input stallVec exp);
        if (got !== exp) begin
            $display("error stall: got 0x%h, expected 0x%h, case %0d", got, exp, caseIdx);
            abortRun("Stall vector mismatch.");
        end
    endtask

    task automatic checkFlush(input flushVec got, input flushVec exp);
        if (got !== exp) begin
            $display("error flush: got 0x%h, expected 0x%h, case %0d", got, exp, caseIdx);
            abortRun("Flush vector mismatch.");
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h, case %0d", name, got, exp, caseIdx);
            abortRun("Control bit mismatch.");
        end
    endtask

    task automatic checkFwd(input int op, input fwdCode got, input fwdCode exp);
        if (got !== exp) begin
            $display("error fwd[%0d]: got 0x%h, expected 0x%h, case %0d",
                     op, got, exp, caseIdx);
            abortRun("Forward code mismatch.");
        end
    endtask

    task automatic checkOp(input int op, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("error opVal[%0d]: got 0x%h, expected 0x%h, case %0d",
                     op, got, exp, caseIdx);
            abortRun("Operand value mismatch.");
        end
    endtask

    task automatic checkCase(input caseLine c);
        fwdCode code;
        checkStall(stall, c.stallExp);
        checkFlush(flush, c.flushExp);
        checkBit("flushEx", flushEx, c.events.excMasterM | c.events.excSlaveM);
        checkBit("icacheCtl", icacheCtl, expectedIcacheCtl(c));
        for (int i = 0; i < 4; i++) begin
            code = fwdCode'(c.fwdExp[4*i +: 4]);
            checkFwd(i, fwd[i], code);
            checkOp(i, opVal[i], expectedOperand(code, i));
        end
    endtask

    initial begin
        rst     = 1'b1;
        decD    = '0;
        rs1D    = '0;
        rt1D    = '0;
        rs2D    = '0;
        rt2D    = '0;
        events  = '0;
        results = '0;
        rfVal   = '0;
        readCases();
        cycleLimit = cases.size() + 20;
        repeat (5) @(posedge clk);
        foreach (cases[k]) begin
            #1;
            rst     = 1'b0;
            caseIdx = k;
            applyCase(cases[k]);
            #98;   // Just ahead of the next edge.
            checkCase(cases[k]);
            @(posedge clk);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/hazard_cases.txt */
# Columns in hex: decMaster decSlave rs1 rt1 rs2 rt2 events, then expected stall flush fwd.
# Tags are 11-bit ctrlSign values; fwd digits from the left are rt2 rs2 rt1 rs1.
# Idle after reset.
000 000 00 00 00 00 000 0000 000 0000
# Fill E to W with writers of r5, r6 and r7.
4a0 4c0 00 00 00 00 000 0000 000 0000
4c0 4a0 00 00 00 00 000 0000 000 0000
4a0 000 00 00 00 00 000 0000 000 0000
4e0 4c0 00 00 00 00 000 0000 000 0000
# Forward priority, youngest stage and slot first, r0 never forwards.
006 006 05 06 07 00 000 0000 000 0483
006 006 05 06 00 07 000 0000 000 3072
006 006 05 06 07 03 000 0000 000 0261
006 006 06 07 05 00 000 0000 000 0015
# Load of r8, used while in E, then in M, then ready at M2.
510 000 00 00 00 00 000 0000 000 0000
006 000 08 00 00 00 000 1e01 060 0004
006 000 08 00 00 00 000 1e01 060 0003
006 000 08 00 00 00 000 0000 000 0002
# mfc0 of r3 stalls only while in E.
468 000 00 00 00 00 000 0000 000 0000
000 006 00 00 03 00 000 1e01 060 0400
000 006 00 00 03 00 000 0000 000 0300
# Slave reads r4 written by its own master.
480 006 00 00 04 01 000 1a00 120 0000
006 000 04 01 00 00 000 0000 000 0004
# Cache miss holds, then miss with a master exception.
006 000 04 00 00 00 400 1ffe 000 0003
006 000 04 00 00 00 208 0ff8 3fe 0003
006 000 04 00 00 00 000 0000 000 0000
# ALU stall with a slave exception.
000 000 00 00 00 00 104 0fe8 3fa 0000
# Jumps and mispredictions, with and without a stall.
000 001 00 00 00 00 001 0000 380 0000
000 000 00 00 00 00 020 0000 3e0 0000
000 000 00 00 00 00 210 0ffe 280 0000
000 000 00 00 00 00 402 1ffe 000 0000
000 000 00 00 00 00 002 0000 280 0000
000 000 00 00 00 00 010 0000 3a0 0000
# Master issues alone.
000 000 00 00 00 00 080 1a00 120 0000
000 000 00 00 00 00 000 0000 000 0000

/* tb.f */
hw/pipeTypes.sv
hw/hazardTypes.sv
hw/fwdSelect.sv
hw/stagePipe.sv
hw/bypassMux.sv
hw/hazard.sv
hw/hazardCore.sv
tests/tb_hazardCore.sv

/* Makefile */
TOP := tb_hazardCore

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f hw/*.sv tests/*.sv
	verilator --binary --timing --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
